// File: Bender.yml
package:
  name: chip8_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/chip8_pkg.sv
      - logic/chip8_sequencer.sv
      - logic/chip8_decoder.sv
      - logic/chip8_alu.sv
      - logic/chip8_reg_file.sv
      - logic/chip8_core.sv
      - target: test
        files:
          - testbench/chip8_sva.sv
          - testbench/tb_chip8_core.sv

// File: compile.f
+incdir+logic
logic/chip8_pkg.sv
logic/chip8_sequencer.sv
logic/chip8_decoder.sv
logic/chip8_alu.sv
logic/chip8_reg_file.sv
logic/chip8_core.sv
testbench/chip8_sva.sv
testbench/tb_chip8_core.sv

// File: logic/chip8_alu.sv
// Byte ALU of the CHIP-8 core, result and VF flag for the 8xy group and the kk forms
`timescale 1ns/1ps
`include "chip8_params.svh"

module chip8_alu (
	input  chip8_pkg::alu_op_e alu_op,
	input  chip8_pkg::byte_t   opnd_a,
	input  chip8_pkg::byte_t   opnd_b,
	output chip8_pkg::byte_t   alu_result,
	output logic               alu_flag
);
	import chip8_pkg::*;

	always_comb begin
		alu_result = '0;
		alu_flag   = 1'b0;
		case (alu_op)
			// Copy of the second operand
			alu_ld:  alu_result = opnd_b;
			alu_or:  alu_result = opnd_a | opnd_b;
			alu_and: alu_result = opnd_a & opnd_b;
			alu_xor: alu_result = opnd_a ^ opnd_b;
			alu_add: begin
				// Carry out of bit 7
				{alu_flag, alu_result} = opnd_a + opnd_b;
			end
			alu_sub: begin
				// Not borrow, equal counts as no borrow
				alu_result = opnd_a - opnd_b;
				alu_flag   = (opnd_a >= opnd_b);
			end
			alu_subn: begin
				alu_result = opnd_b - opnd_a;
				alu_flag   = (opnd_b >= opnd_a);
			end
			alu_shr: begin
				// Bit shifted out goes to VF
				alu_result = opnd_a >> 1;
				alu_flag   = opnd_a[0];
			end
			alu_shl: begin
				alu_result = opnd_a << 1;
				alu_flag   = opnd_a[`CHIP8_BYTE_W-1];
			end
			default: begin
				alu_result = '0;
				alu_flag   = 1'b0;
			end
		endcase
	end

endmodule

// File: logic/chip8_core.sv
// Top of the CHIP-8 executor core, instruction in on issue, state report out on retire
`timescale 1ns/1ps

module chip8_core (
	input  logic                    cpu_clk,
	input  logic                    rst_n,
	input  logic                    issue,
	input  chip8_pkg::instr_t       instr,
	output logic                    retire,
	output chip8_pkg::retire_info_t retire_info
);
	import chip8_pkg::*;

	instr_t      op_instr;
	decoded_op_t op;
	byte_t       opnd_a;
	byte_t       opnd_b;
	byte_t       alu_result;
	logic        alu_flag;
	logic        capture;
	logic        commit;

	// Steps each instruction, fixed 3 cycle latency
	chip8_sequencer u_sequencer (
		.cpu_clk  (cpu_clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.instr    (instr),
		.op_instr (op_instr),
		.capture  (capture),
		.commit   (commit),
		.retire   (retire)
	);

	chip8_decoder u_decoder (
		.op_instr (op_instr),
		.op       (op)
	);

	// Works on the operands captured in the read step
	chip8_alu u_alu (
		.alu_op     (op.alu_op),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b),
		.alu_result (alu_result),
		.alu_flag   (alu_flag)
	);

	chip8_reg_file u_reg_file (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.op          (op),
		.capture     (capture),
		.commit      (commit),
		.alu_result  (alu_result),
		.alu_flag    (alu_flag),
		.opnd_a      (opnd_a),
		.opnd_b      (opnd_b),
		.retire_info (retire_info)
	);

endmodule

// File: logic/chip8_decoder.sv
// Decodes a latched CHIP-8 instruction word into the operation struct for the core
`timescale 1ns/1ps

module chip8_decoder (
	input  chip8_pkg::instr_t      op_instr,
	output chip8_pkg::decoded_op_t op
);
	import chip8_pkg::*;

	op_kind_e kind;
	alu_op_e  alu_op;

	always_comb begin
		kind   = op_nop;
		alu_op = alu_none;
		// Top nibble picks the class
		case (op_instr[15:12])
			4'h1: kind = op_jump;
			4'hB: kind = op_jump_v0;
			4'h3: kind = op_skip_eq_imm;
			4'h4: kind = op_skip_ne_imm;
			4'h5: begin
				// Only 5xy0 is defined
				if (op_instr[3:0] == 4'h0) begin
					kind = op_skip_eq_reg;
				end
			end
			4'h9: begin
				if (op_instr[3:0] == 4'h0) begin
					kind = op_skip_ne_reg;
				end
			end
			4'h6: begin
				// ALU passes kk through
				kind   = op_load_imm;
				alu_op = alu_ld;
			end
			4'h7: begin
				// Flag from this add is dropped later
				kind   = op_add_imm;
				alu_op = alu_add;
			end
			4'h8: begin
				kind = op_alu_reg;
				case (op_instr[3:0])
					4'h0: alu_op = alu_ld;
					4'h1: alu_op = alu_or;
					4'h2: alu_op = alu_and;
					4'h3: alu_op = alu_xor;
					4'h4: alu_op = alu_add;
					4'h5: alu_op = alu_sub;
					4'h6: alu_op = alu_shr;
					4'h7: alu_op = alu_subn;
					4'hE: alu_op = alu_shl;
					default: begin
						// 8xy8..8xyD and 8xyF fall back to nop
						kind   = op_nop;
						alu_op = alu_none;
					end
				endcase
			end
			4'hA: kind = op_load_i;
			4'hF: begin
				// Fx1E is the only F form kept
				if (op_instr[7:0] == 8'h1E) begin
					kind = op_add_i;
				end
			end
			default: kind = op_nop;
		endcase
	end

	// Fields are extracted whatever the class
	assign op.kind   = kind;
	assign op.alu_op = alu_op;
	assign op.x      = op_instr[11:8];
	assign op.y      = op_instr[7:4];
	assign op.kk     = op_instr[7:0];
	assign op.nnn    = op_instr[11:0];

endmodule

// File: logic/chip8_params.svh
// Width and constant macros for the CHIP-8 core, included by the package and the RTL
`ifndef CHIP8_PARAMS_SVH
`define CHIP8_PARAMS_SVH

// Data byte width, one Vx register
`define CHIP8_BYTE_W 8

// Address width for PC, I and nnn
`define CHIP8_ADDR_W 12

// One instruction word
`define CHIP8_INSTR_W 16

// Index into V0..VF
`define CHIP8_REG_IDX_W 4

// Programs start here, below is interpreter space
`define CHIP8_PC_RESET 12'h200

// Bytes per instruction
`define CHIP8_PC_STEP 2

// VF carries the flag results
`define CHIP8_FLAG_REG 4'hF

`endif

// File: logic/chip8_pkg.sv
// Shared types of the CHIP-8 core, imported by the RTL and the testbench
`include "chip8_params.svh"

package chip8_pkg;

	// Plain vectors with a meaning
	typedef logic [`CHIP8_BYTE_W-1:0]    byte_t;
	typedef logic [`CHIP8_ADDR_W-1:0]    addr_t;
	typedef logic [`CHIP8_INSTR_W-1:0]   instr_t;
	typedef logic [`CHIP8_REG_IDX_W-1:0] reg_idx_t;

	// ALU operations, 8xy group plus the 6xkk and 7xkk forms
	typedef enum logic [3:0] {
		alu_none,
		alu_ld,
		alu_or,
		alu_and,
		alu_xor,
		alu_add,
		alu_sub,
		alu_subn,
		alu_shr,
		alu_shl
	} alu_op_e;

	// Instruction classes the register file acts on
	typedef enum logic [3:0] {
		op_nop,
		op_jump,
		op_jump_v0,
		op_skip_eq_imm,
		op_skip_ne_imm,
		op_skip_eq_reg,
		op_skip_ne_reg,
		op_load_imm,
		op_add_imm,
		op_alu_reg,
		op_load_i,
		op_add_i
	} op_kind_e;

	// Execution steps of one instruction
	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_exec,
		st_retire
	} seq_state_e;

	// Decoder output, fields pulled straight from the word
	typedef struct packed {
		op_kind_e kind;
		alu_op_e  alu_op;
		reg_idx_t x;
		reg_idx_t y;
		byte_t    kk;
		addr_t    nnn;
	} decoded_op_t;

	// State after an instruction, plus the register writes it made
	typedef struct packed {
		addr_t    pc;
		addr_t    i_reg;
		logic     v_wr_en;
		reg_idx_t v_wr_idx;
		byte_t    v_wr_data;
		logic     vf_wr_en;
		byte_t    vf_wr_data;
	} retire_info_t;

endpackage

// File: logic/chip8_reg_file.sv
// CHIP-8 architectural state: V0-VF, I and PC, operand capture and result commit
`timescale 1ns/1ps
`include "chip8_params.svh"

module chip8_reg_file (
	input  logic                    cpu_clk,
	input  logic                    rst_n,
	input  chip8_pkg::decoded_op_t  op,
	input  logic                    capture,
	input  logic                    commit,
	input  chip8_pkg::byte_t        alu_result,
	input  logic                    alu_flag,
	output chip8_pkg::byte_t        opnd_a,
	output chip8_pkg::byte_t        opnd_b,
	output chip8_pkg::retire_info_t retire_info
);
	import chip8_pkg::*;

	byte_t v_regs [16];
	addr_t i_reg;
	addr_t pc;
	addr_t pc_next;
	addr_t i_next;
	addr_t opnd_a_wide;
	logic  opnds_eq;
	logic  v_wr_en;
	logic  vf_wr_en;
	logic  v_wr_en_q;
	reg_idx_t v_wr_idx_q;
	byte_t v_wr_data_q;
	logic  vf_wr_en_q;
	byte_t vf_wr_data_q;

	// Read step, Bnnn reads V0 and the kk forms take the immediate
	always_ff @(posedge cpu_clk) begin
		if (capture) begin
			opnd_a <= (op.kind == op_jump_v0) ? v_regs[0] : v_regs[op.x];
			case (op.kind)
				op_skip_eq_imm, op_skip_ne_imm, op_load_imm, op_add_imm: opnd_b <= op.kk;
				default: opnd_b <= v_regs[op.y];
			endcase
		end
	end

	assign opnds_eq    = (opnd_a == opnd_b);
	assign opnd_a_wide = {{(`CHIP8_ADDR_W-`CHIP8_BYTE_W){1'b0}}, opnd_a};

	// Next PC and I, plus which registers this op writes
	always_comb begin
		pc_next  = pc + addr_t'(`CHIP8_PC_STEP);
		i_next   = i_reg;
		v_wr_en  = 1'b0;
		vf_wr_en = 1'b0;
		case (op.kind)
			op_jump:    pc_next = op.nnn;
			// Wraps at 4096
			op_jump_v0: pc_next = op.nnn + opnd_a_wide;
			op_skip_eq_imm, op_skip_eq_reg: begin
				if (opnds_eq) begin
					pc_next = pc + addr_t'(2 * `CHIP8_PC_STEP);
				end
			end
			op_skip_ne_imm, op_skip_ne_reg: begin
				if (!opnds_eq) begin
					pc_next = pc + addr_t'(2 * `CHIP8_PC_STEP);
				end
			end
			op_load_imm, op_add_imm: v_wr_en = 1'b1;
			op_alu_reg: begin
				v_wr_en = 1'b1;
				// Logic ops and plain copy leave VF alone
				vf_wr_en = (op.alu_op inside {alu_add, alu_sub, alu_subn, alu_shr, alu_shl});
			end
			op_load_i:  i_next = op.nnn;
			op_add_i:   i_next = i_reg + opnd_a_wide;
			default:    pc_next = pc + addr_t'(`CHIP8_PC_STEP);
		endcase
	end

	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			v_regs <= '{default: '0};
			i_reg  <= '0;
			pc     <= `CHIP8_PC_RESET;
		end else if (commit) begin
			pc    <= pc_next;
			i_reg <= i_next;
			if (v_wr_en) begin
				v_regs[op.x] <= alu_result;
			end
			// Placed last so the flag wins when x is F
			if (vf_wr_en) begin
				v_regs[`CHIP8_FLAG_REG] <= {{(`CHIP8_BYTE_W-1){1'b0}}, alu_flag};
			end
		end
	end

	// Write record held for the retire step
	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			v_wr_en_q    <= 1'b0;
			v_wr_idx_q   <= '0;
			v_wr_data_q  <= '0;
			vf_wr_en_q   <= 1'b0;
			vf_wr_data_q <= '0;
		end else if (commit) begin
			v_wr_en_q    <= v_wr_en;
			v_wr_idx_q   <= op.x;
			v_wr_data_q  <= alu_result;
			vf_wr_en_q   <= vf_wr_en;
			vf_wr_data_q <= {{(`CHIP8_BYTE_W-1){1'b0}}, alu_flag};
		end
	end

	// PC and I are already the post-instruction values in retire
	assign retire_info.pc         = pc;
	assign retire_info.i_reg      = i_reg;
	assign retire_info.v_wr_en    = v_wr_en_q;
	assign retire_info.v_wr_idx   = v_wr_idx_q;
	assign retire_info.v_wr_data  = v_wr_data_q;
	assign retire_info.vf_wr_en   = vf_wr_en_q;
	assign retire_info.vf_wr_data = vf_wr_data_q;

endmodule

// File: logic/chip8_sequencer.sv
// FSM that latches an issued CHIP-8 instruction and steps it through read, exec, retire
`timescale 1ns/1ps

module chip8_sequencer (
	input  logic              cpu_clk,
	input  logic              rst_n,
	input  logic              issue,
	input  chip8_pkg::instr_t instr,
	output chip8_pkg::instr_t op_instr,
	output logic              capture,
	output logic              commit,
	output logic              retire
);
	import chip8_pkg::*;

	seq_state_e state;
	seq_state_e state_next;
	instr_t     instr_q;

	// Only idle listens to issue, the rest is a fixed walk
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (issue) begin
					state_next = st_read;
				end
			end
			st_read:   state_next = st_exec;
			st_exec:   state_next = st_retire;
			st_retire: state_next = st_idle;
			default:   state_next = st_idle;
		endcase
	end

	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// Word held steady for the decoder until the next accepted issue
	always_ff @(posedge cpu_clk) begin
		if (state == st_idle && issue) begin
			instr_q <= instr;
		end
	end

	assign op_instr = instr_q;

	// One strobe per step, straight from the state
	assign capture = (state == st_read);
	assign commit  = (state == st_exec);
	assign retire  = (state == st_retire);

endmodule

// File: testbench/chip8_sva.sv
// Concurrent assertions on the CHIP-8 sequencer and bound into every chip8_sequencer instance
`timescale 1ns/1ps

module chip8_sva (
	input logic                  cpu_clk,
	input logic                  rst_n,
	input logic                  issue,
	input chip8_pkg::seq_state_e state,
	input logic                  capture,
	input logic                  commit,
	input logic                  retire
);
	import chip8_pkg::*;

	// Accepted issue retires on the third edge and not earlier
	a_issue_to_retire: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		(state == st_idle && issue) |=> !retire ##1 !retire ##1 retire)
		else $error("retire did not follow an accepted issue by 3 cycles");

	// Single cycle strobe
	a_retire_single: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		retire |=> !retire)
		else $error("retire stayed high for two cycles");

	// Capture leads commit by one step and never overlaps it
	a_capture_commit_excl: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		capture |-> !commit ##1 (commit && !capture))
		else $error("commit did not follow capture alone in the next cycle");

endmodule

bind chip8_sequencer chip8_sva u_sva (
	.cpu_clk (cpu_clk),
	.rst_n   (rst_n),
	.issue   (issue),
	.state   (state),
	.capture (capture),
	.commit  (commit),
	.retire  (retire)
);

// File: testbench/tb_chip8_core.sv
// Randomized testbench for the CHIP-8 core, every retire is checked against a reference model
`timescale 1ns/1ps
`include "chip8_params.svh"

module tb_chip8_core;
	import chip8_pkg::*;

	logic         cpu_clk;
	logic         rst_n;
	logic         issue;
	instr_t       instr;
	logic         retire;
	retire_info_t retire_info;

	integer seed;
	integer error_count;
	integer check_count;
	logic   timed_out;

	// Reference state of V0-VF, I and PC
	byte_t m_v [16];
	addr_t m_i;
	addr_t m_pc;

	chip8_core u_dut (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.issue       (issue),
		.instr       (instr),
		.retire      (retire),
		.retire_info (retire_info)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #4 cpu_clk = ~cpu_clk;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// Executes one word on the model and returns the retire record it should produce
	task automatic apply_model(input instr_t w, output retire_info_t exp);
		reg_idx_t   x;
		byte_t      kk;
		byte_t      vx;
		byte_t      vy;
		byte_t      res;
		addr_t      nnn;
		addr_t      pc_n;
		logic [8:0] sum;
		logic       flag;
		logic       wr_v;
		logic       wr_f;
		x    = w[11:8];
		kk   = w[7:0];
		nnn  = w[11:0];
		vx   = m_v[x];
		vy   = m_v[w[7:4]];
		res  = '0;
		flag = 1'b0;
		wr_v = 1'b0;
		wr_f = 1'b0;
		pc_n = m_pc + 12'd2;
		case (w[15:12])
			4'h1: pc_n = nnn;
			4'hB: pc_n = nnn + {4'h0, m_v[0]};
			4'h3: if (vx == kk) pc_n = m_pc + 12'd4;
			4'h4: if (vx != kk) pc_n = m_pc + 12'd4;
			4'h5: if (w[3:0] == 4'h0 && vx == vy) pc_n = m_pc + 12'd4;
			4'h9: if (w[3:0] == 4'h0 && vx != vy) pc_n = m_pc + 12'd4;
			4'h6: begin
				res  = kk;
				wr_v = 1'b1;
			end
			4'h7: begin
				res  = vx + kk;
				wr_v = 1'b1;
			end
			4'h8: begin
				wr_v = 1'b1;
				wr_f = (w[3:0] inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE});
				case (w[3:0])
					4'h0: res = vy;
					4'h1: res = vx | vy;
					4'h2: res = vx & vy;
					4'h3: res = vx ^ vy;
					4'h4: begin
						sum  = {1'b0, vx} + {1'b0, vy};
						res  = sum[7:0];
						flag = sum[8];
					end
					4'h5: begin
						res  = vx - vy;
						flag = (vx >= vy);
					end
					4'h6: begin
						res  = vx >> 1;
						flag = vx[0];
					end
					4'h7: begin
						res  = vy - vx;
						flag = (vy >= vx);
					end
					4'hE: begin
						res  = vx << 1;
						flag = vx[7];
					end
					default: wr_v = 1'b0;
				endcase
			end
			4'hA: m_i = nnn;
			4'hF: if (kk == 8'h1E) m_i = m_i + {4'h0, vx};
			default: pc_n = m_pc + 12'd2;
		endcase
		if (wr_v) m_v[x] = res;
		// VF goes second so the flag overwrites a result aimed at VF
		if (wr_f) m_v[15] = {7'b0, flag};
		m_pc = pc_n;
		exp.pc         = m_pc;
		exp.i_reg      = m_i;
		exp.v_wr_en    = wr_v;
		exp.v_wr_idx   = x;
		exp.v_wr_data  = res;
		exp.vf_wr_en   = wr_f;
		exp.vf_wr_data = {7'b0, flag};
	endtask

	// Random word, mostly kept opcodes, skips biased so both outcomes happen
	function automatic instr_t gen_instr();
		reg_idx_t x;
		reg_idx_t y;
		byte_t    kk;
		logic [3:0] sub;
		instr_t   w;
		x  = $random(seed);
		y  = $random(seed);
		kk = $random(seed);
		w  = $random(seed);
		case ({$random(seed)} % 16)
			0, 1: w = {4'h6, x, kk};
			2: w = {4'h7, x, kk};
			3, 4, 5, 6: begin
				sub = 4'({$random(seed)} % 9);
				w = {4'h8, x, y, (sub == 4'd8) ? 4'hE : sub};
			end
			7: begin
				if ($random(seed) & 1) kk = m_v[x];
				w = {($random(seed) & 1) ? 4'h3 : 4'h4, x, kk};
			end
			8: begin
				if ($random(seed) & 1) y = x;
				w = {($random(seed) & 1) ? 4'h5 : 4'h9, x, y, 4'h0};
			end
			9: w = {4'h1, w[11:0]};
			10: w = {4'hB, w[11:0]};
			11: w = {4'hA, w[11:0]};
			12: w = {4'hF, x, 8'h1E};
			13: w = {4'hC, w[11:0]};
			default: w = w;
		endcase
		return w;
	endfunction

	task automatic run_instr(input instr_t w);
		retire_info_t exp;
		integer       cycles;
		if (!timed_out) begin
			apply_model(w, exp);
			@(negedge cpu_clk);
			issue  = 1'b1;
			instr  = w;
			cycles = 0;
			do begin
				@(negedge cpu_clk);
				issue = 1'b0;
				cycles++;
			end while (!retire && cycles < 20);
			if (!retire) begin
				$display("Timeout: instruction %h never retired within 20 cycles", w);
				error_count++;
				timed_out = 1'b1;
			end else begin
				check("retire_latency", 3, cycles);
				check("pc", exp.pc, retire_info.pc);
				check("i_reg", exp.i_reg, retire_info.i_reg);
				check("v_wr_en", exp.v_wr_en, retire_info.v_wr_en);
				check("vf_wr_en", exp.vf_wr_en, retire_info.vf_wr_en);
				// Index and data only carry meaning with their enable
				if (exp.v_wr_en) begin
					check("v_wr_idx", exp.v_wr_idx, retire_info.v_wr_idx);
					check("v_wr_data", exp.v_wr_data, retire_info.v_wr_data);
				end
				if (exp.vf_wr_en) check("vf_wr_data", exp.vf_wr_data, retire_info.vf_wr_data);
			end
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	initial begin
		seed        = 32'he16c1949;
		error_count = 0;
		check_count = 0;
		timed_out   = 1'b0;
		issue       = 1'b0;
		instr       = '0;
		rst_n       = 1'b0;
		m_v         = '{default: '0};
		m_i         = '0;
		m_pc        = `CHIP8_PC_RESET;
		repeat (10) @(negedge cpu_clk);
		rst_n = 1'b1;
		// Copy from a zero register right after reset
		run_instr(16'h8120);
		// Immediate load and add, with wrap and with x = F
		run_instr(16'h6A37);
		run_instr(16'h7AF0);
		run_instr(16'h7F05);
		// 8xy group on preloaded values, VF as destination too
		run_instr(16'h6381);
		run_instr(16'h64C2);
		run_instr(16'h8344);
		run_instr(16'h6F90);
		run_instr(16'h8F45);
		run_instr(16'h8436);
		run_instr(16'h843E);
		run_instr(16'h8347);
		run_instr(16'h8341);
		run_instr(16'h8342);
		run_instr(16'h8343);
		// Skips, taken and not taken
		run_instr(16'h3A27);
		run_instr(16'h4A27);
		run_instr(16'h5340);
		run_instr(16'h5330);
		run_instr(16'h9330);
		run_instr(16'h9340);
		// Jumps, I updates and wrap past 4095
		run_instr(16'h1ABC);
		run_instr(16'h6010);
		run_instr(16'hB3F8);
		run_instr(16'hA123);
		run_instr(16'hFA1E);
		run_instr(16'hBFFF);
		// Unsupported words retire as nops
		run_instr(16'h00E0);
		run_instr(16'hE19E);
		run_instr(16'h8128);
		run_instr(16'h5121);
		for (int n = 0; n < 2000 && !timed_out; n++) begin
			run_instr(gen_instr());
		end
		finish_run();
	end

endmodule
